// ==== include/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Address and word
`define DCACHE_ADDR_W     32
`define DCACHE_DATA_W     32

// Cache geometry
`define DCACHE_SETS       4
`define DCACHE_WAYS       4
`define DCACHE_LINE_WORDS 16

// Address split into tag, index and byte offset
`define DCACHE_OFFSET_W   6
`define DCACHE_INDEX_W    2
`define DCACHE_TAG_W      24

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]               addr_t;
    typedef logic [`DCACHE_DATA_W-1:0]               word_t;
    typedef logic [`DCACHE_TAG_W-1:0]                tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]              set_idx_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0]         way_idx_t;
    typedef logic [$clog2(`DCACHE_LINE_WORDS)-1:0]   word_idx_t;
    typedef logic [`DCACHE_DATA_W/8-1:0]             byte_en_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_ADDR,   // Victim line address out
        WB_DATA,   // Victim line beats out
        RF_ADDR,
        RF_DATA,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== src/dcache_tag_array.sv ====
`include "dcache_settings.svh"

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::addr_t    lookup_addr,
    input  logic                 fill,
    input  logic                 mark_dirty,
    output logic                 hit,
    output dcache_pkg::way_idx_t hit_way,
    output dcache_pkg::way_idx_t victim_way,
    output logic                 victim_dirty,
    output dcache_pkg::tag_t     victim_tag
);

    dcache_pkg::tag_t        tags [`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] valid [`DCACHE_SETS];
    logic [`DCACHE_WAYS-1:0] dirty [`DCACHE_SETS];
    dcache_pkg::way_idx_t    rr_ptr [`DCACHE_SETS];   // Next victim per set

    dcache_pkg::set_idx_t    set_idx;
    dcache_pkg::tag_t        tag;
    logic [`DCACHE_WAYS-1:0] match;

    assign set_idx = lookup_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign tag     = lookup_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            match[w] = valid[set_idx][w] && (tags[set_idx][w] == tag);
            if (match[w]) begin
                hit_way = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit          = |match;
    assign victim_way   = rr_ptr[set_idx];
    assign victim_dirty = valid[set_idx][victim_way] && dirty[set_idx][victim_way];
    assign victim_tag   = tags[set_idx][victim_way];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid[s]  <= '0;
                dirty[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else begin
            if (fill) begin
                valid[set_idx][victim_way] <= 1'b1;
                dirty[set_idx][victim_way] <= 1'b0;   // Fresh line is clean
                rr_ptr[set_idx]            <= victim_way + 1'b1;
            end
            if (mark_dirty) begin
                dirty[set_idx][hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[set_idx][victim_way] <= tag;
        end
    end

    // A refill never duplicates a line that is already present
    a_single_match: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match));

endmodule

// ==== src/dcache_data_array.sv ====
`include "dcache_settings.svh"

module dcache_data_array (
    input  logic                  clk,
    input  dcache_pkg::set_idx_t  set_idx,
    input  dcache_pkg::way_idx_t  way,
    input  dcache_pkg::word_idx_t word,
    input  dcache_pkg::byte_en_t  write_en,
    input  dcache_pkg::word_t     write_data,
    output dcache_pkg::word_t     read_data
);

    dcache_pkg::word_t mem [`DCACHE_SETS][`DCACHE_WAYS][`DCACHE_LINE_WORDS];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DCACHE_DATA_W/8; b++) begin
            if (write_en[b]) begin
                mem[set_idx][way][word][b*8 +: 8] <= write_data[b*8 +: 8];
            end
        end
    end

    assign read_data = mem[set_idx][way][word];   // Asynchronous read

endmodule

// ==== src/dcache_ctrl.sv ====
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dcache_pkg::addr_t     s_addr,
    input  logic                  s_arvalid,
    input  dcache_pkg::byte_en_t  s_awvalid,
    input  dcache_pkg::word_t     s_wdata,
    output dcache_pkg::word_t     s_rdata,
    output logic                  s_rvalid,
    output logic                  s_wready,
    output dcache_pkg::addr_t     m_araddr,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  dcache_pkg::word_t     m_rdata,
    input  logic                  m_rvalid,
    input  logic                  m_rlast,
    output logic                  m_rready,
    output dcache_pkg::addr_t     m_awaddr,
    output logic                  m_awvalid,
    input  logic                  m_awready,
    output dcache_pkg::word_t     m_wdata,
    output logic                  m_wvalid,
    output logic                  m_wlast,
    input  logic                  m_wready,
    output logic                  m_bready,
    output dcache_pkg::addr_t     req_addr,
    output logic                  fill,
    output logic                  mark_dirty,
    input  logic                  hit,
    input  dcache_pkg::way_idx_t  hit_way,
    input  dcache_pkg::way_idx_t  victim_way,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    output dcache_pkg::way_idx_t  arr_way,
    output dcache_pkg::word_idx_t arr_word,
    output dcache_pkg::byte_en_t  arr_be,
    output dcache_pkg::word_t     arr_wdata,
    input  dcache_pkg::word_t     arr_rdata
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::byte_en_t    req_be;
    dcache_pkg::word_t       req_wdata;
    dcache_pkg::word_idx_t   beat;        // Burst word counter
    logic                    req_write;
    logic                    in_burst;

    assign req_write = |req_be;           // Reads carry no byte enables
    assign in_burst  = (state == dcache_pkg::WB_DATA) || (state == dcache_pkg::RF_DATA);

    assign m_rready = 1'b1;
    assign m_bready = 1'b1;
    assign m_wvalid = (state == dcache_pkg::WB_DATA);
    assign m_wlast  = m_wvalid && (beat == '1);
    assign m_wdata  = arr_rdata;

    assign mark_dirty = (state == dcache_pkg::LOOKUP) && hit && req_write;
    assign fill       = (state == dcache_pkg::RF_DATA) && m_rvalid && m_rlast;

    assign arr_way   = (state == dcache_pkg::LOOKUP) ? hit_way : victim_way;
    assign arr_word  = in_burst ? beat : req_addr[`DCACHE_OFFSET_W-1:2];
    assign arr_wdata = (state == dcache_pkg::RF_DATA) ? m_rdata : req_wdata;

    always_comb begin
        arr_be = '0;
        if (mark_dirty) begin
            arr_be = req_be;                          // Merge into hit line
        end else if (state == dcache_pkg::RF_DATA && m_rvalid) begin
            arr_be = '1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= dcache_pkg::IDLE;
            req_addr  <= '0;
            beat      <= '0;
            m_arvalid <= 1'b0;
            m_awvalid <= 1'b0;
            s_rvalid  <= 1'b0;
            s_wready  <= 1'b0;
        end else begin
            s_rvalid <= 1'b0;
            s_wready <= 1'b0;
            case (state)
                dcache_pkg::IDLE: begin
                    req_addr <= s_addr;
                    if (s_arvalid || (|s_awvalid)) begin
                        state <= dcache_pkg::LOOKUP;
                    end
                end
                dcache_pkg::LOOKUP: begin
                    if (hit) begin
                        s_rvalid <= !req_write;
                        s_wready <= req_write;
                        state    <= dcache_pkg::RESPOND;
                    end else if (victim_dirty) begin
                        m_awvalid <= 1'b1;
                        state     <= dcache_pkg::WB_ADDR;
                    end else begin
                        m_arvalid <= 1'b1;
                        state     <= dcache_pkg::RF_ADDR;
                    end
                end
                dcache_pkg::WB_ADDR: begin
                    if (m_awready) begin
                        m_awvalid <= 1'b0;
                        beat      <= '0;
                        state     <= dcache_pkg::WB_DATA;
                    end
                end
                dcache_pkg::WB_DATA: begin
                    if (m_wready) begin
                        beat <= beat + 1'b1;
                        if (m_wlast) begin
                            m_arvalid <= 1'b1;   // Refill follows write-back
                            state     <= dcache_pkg::RF_ADDR;
                        end
                    end
                end
                dcache_pkg::RF_ADDR: begin
                    if (m_arready) begin
                        m_arvalid <= 1'b0;
                        beat      <= '0;
                        state     <= dcache_pkg::RF_DATA;
                    end
                end
                dcache_pkg::RF_DATA: begin
                    if (m_rvalid) begin
                        beat <= beat + 1'b1;
                        if (m_rlast) begin
                            state <= dcache_pkg::LOOKUP;   // Retry, now a hit
                        end
                    end
                end
                dcache_pkg::RESPOND: state <= dcache_pkg::IDLE;
                default:             state <= dcache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::IDLE) begin
            req_be    <= s_awvalid;
            req_wdata <= s_wdata;
        end
        if (state == dcache_pkg::LOOKUP && hit && !req_write) begin
            s_rdata <= arr_rdata;
        end
        if (state == dcache_pkg::LOOKUP && !hit) begin
            m_awaddr <= {victim_tag, req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W],
                         {`DCACHE_OFFSET_W{1'b0}}};
            m_araddr <= {req_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
        end
    end

    // Write beat held under back-pressure
    a_wbeat_held: assert property (@(posedge clk) disable iff (!rst_n)
        m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wlast));

    // Response matches the request still held
    a_resp_type: assert property (@(posedge clk) disable iff (!rst_n)
        (!s_rvalid || s_arvalid) && (!s_wready || (|s_awvalid)));

endmodule

// ==== src/dcache_top.sv ====
`include "dcache_settings.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::addr_t    s_addr,
    input  logic                 s_arvalid,
    input  dcache_pkg::byte_en_t s_awvalid,
    input  dcache_pkg::word_t    s_wdata,
    output dcache_pkg::word_t    s_rdata,
    output logic                 s_rvalid,
    output logic                 s_wready,
    output dcache_pkg::addr_t    m_araddr,
    output logic                 m_arvalid,
    input  logic                 m_arready,
    input  dcache_pkg::word_t    m_rdata,
    input  logic                 m_rvalid,
    input  logic                 m_rlast,
    output logic                 m_rready,
    output dcache_pkg::addr_t    m_awaddr,
    output logic                 m_awvalid,
    input  logic                 m_awready,
    output dcache_pkg::word_t    m_wdata,
    output logic                 m_wvalid,
    output logic                 m_wlast,
    input  logic                 m_wready,
    output logic                 m_bready
);

    dcache_pkg::addr_t     req_addr;
    dcache_pkg::set_idx_t  set_idx;
    logic                  fill;
    logic                  mark_dirty;
    logic                  hit;
    dcache_pkg::way_idx_t  hit_way;
    dcache_pkg::way_idx_t  victim_way;
    logic                  victim_dirty;
    dcache_pkg::tag_t      victim_tag;
    dcache_pkg::way_idx_t  arr_way;
    dcache_pkg::word_idx_t arr_word;
    dcache_pkg::byte_en_t  arr_be;
    dcache_pkg::word_t     arr_wdata;
    dcache_pkg::word_t     arr_rdata;

    assign set_idx = req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_addr       (s_addr),
        .s_arvalid    (s_arvalid),
        .s_awvalid    (s_awvalid),
        .s_wdata      (s_wdata),
        .s_rdata      (s_rdata),
        .s_rvalid     (s_rvalid),
        .s_wready     (s_wready),
        .m_araddr     (m_araddr),
        .m_arvalid    (m_arvalid),
        .m_arready    (m_arready),
        .m_rdata      (m_rdata),
        .m_rvalid     (m_rvalid),
        .m_rlast      (m_rlast),
        .m_rready     (m_rready),
        .m_awaddr     (m_awaddr),
        .m_awvalid    (m_awvalid),
        .m_awready    (m_awready),
        .m_wdata      (m_wdata),
        .m_wvalid     (m_wvalid),
        .m_wlast      (m_wlast),
        .m_wready     (m_wready),
        .m_bready     (m_bready),
        .req_addr     (req_addr),
        .fill         (fill),
        .mark_dirty   (mark_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .arr_way      (arr_way),
        .arr_word     (arr_word),
        .arr_be       (arr_be),
        .arr_wdata    (arr_wdata),
        .arr_rdata    (arr_rdata)
    );

    dcache_tag_array i_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_addr  (req_addr),
        .fill         (fill),
        .mark_dirty   (mark_dirty),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_array i_data (
        .clk        (clk),
        .set_idx    (set_idx),
        .way        (arr_way),
        .word       (arr_word),
        .write_en   (arr_be),
        .write_data (arr_wdata),
        .read_data  (arr_rdata)
    );

endmodule

// ==== testbench/mem_model.sv ====
`include "dcache_settings.svh"

module mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall_en,
    input  dcache_pkg::addr_t m_araddr,
    input  logic              m_arvalid,
    output logic              m_arready,
    output dcache_pkg::word_t m_rdata,
    output logic              m_rvalid,
    output logic              m_rlast,
    input  logic              m_rready,
    input  dcache_pkg::addr_t m_awaddr,
    input  logic              m_awvalid,
    output logic              m_awready,
    input  dcache_pkg::word_t m_wdata,
    input  logic              m_wvalid,
    input  logic              m_wlast,
    output logic              m_wready,
    output int                read_bursts,
    output int                write_bursts
);

    dcache_pkg::word_t     mem [logic [29:0]];   // Only words written back
    integer                seed = 69;
    logic [31:0]           stall_bits = '0;
    logic                  rd_active = 1'b0;
    logic                  wr_active = 1'b0;
    dcache_pkg::addr_t     rd_addr;
    dcache_pkg::addr_t     wr_addr;
    dcache_pkg::word_idx_t rd_beat;
    dcache_pkg::word_idx_t wr_beat;
    dcache_pkg::word_t     rdata_q = '0;
    logic                  rvalid_q = 1'b0;
    logic                  rlast_q = 1'b0;
    logic                  rd_gap;

    // Untouched words hold their own byte address XOR a fixed pattern
    function automatic dcache_pkg::word_t load_word(input dcache_pkg::addr_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    // About one cycle in four stalls when enabled
    assign m_arready = !rd_active && (!stall_en || stall_bits[1:0] != 2'b00);
    assign m_awready = !wr_active && (!stall_en || stall_bits[3:2] != 2'b00);
    assign m_wready  = wr_active && (!stall_en || stall_bits[5:4] != 2'b00);
    assign rd_gap    = stall_en && (stall_bits[7:6] == 2'b00);
    assign m_rdata   = rdata_q;
    assign m_rvalid  = rvalid_q;
    assign m_rlast   = rlast_q;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_bits <= '0;
        end else begin
            stall_bits <= $random(seed);
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.delete();
            rd_active    <= 1'b0;
            wr_active    <= 1'b0;
            rvalid_q     <= 1'b0;
            rlast_q      <= 1'b0;
            read_bursts  <= 0;
            write_bursts <= 0;
        end else begin
            if (m_arvalid && m_arready) begin
                rd_active   <= 1'b1;
                rd_addr     <= m_araddr;
                rd_beat     <= '0;
                read_bursts <= read_bursts + 1;
            end
            if (!rvalid_q || m_rready) begin   // Current beat taken or none shown
                if (rd_active && !rd_gap) begin
                    rvalid_q  <= 1'b1;
                    rdata_q   <= load_word({rd_addr[31:6], rd_beat, 2'b00});
                    rlast_q   <= (rd_beat == 4'(`DCACHE_LINE_WORDS - 1));
                    rd_beat   <= rd_beat + 1'b1;
                    rd_active <= (rd_beat != 4'(`DCACHE_LINE_WORDS - 1));
                end else begin
                    rvalid_q <= 1'b0;
                    rlast_q  <= 1'b0;
                end
            end
            if (m_awvalid && m_awready) begin
                wr_active    <= 1'b1;
                wr_addr      <= m_awaddr;
                wr_beat      <= '0;
                write_bursts <= write_bursts + 1;
            end
            if (m_wvalid && m_wready) begin
                mem[{wr_addr[31:6], wr_beat}] = m_wdata;
                wr_beat <= wr_beat + 1'b1;
                if (m_wlast) begin
                    wr_active <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_dcache.sv ====
module tb_dcache;

    localparam int RESP_TIMEOUT = 1000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 stall_en;
    dcache_pkg::addr_t    s_addr;
    logic                 s_arvalid;
    dcache_pkg::byte_en_t s_awvalid;
    dcache_pkg::word_t    s_wdata;
    dcache_pkg::word_t    s_rdata;
    logic                 s_rvalid;
    logic                 s_wready;
    dcache_pkg::addr_t    m_araddr;
    logic                 m_arvalid;
    logic                 m_arready;
    dcache_pkg::word_t    m_rdata;
    logic                 m_rvalid;
    logic                 m_rlast;
    logic                 m_rready;
    dcache_pkg::addr_t    m_awaddr;
    logic                 m_awvalid;
    logic                 m_awready;
    dcache_pkg::word_t    m_wdata;
    logic                 m_wvalid;
    logic                 m_wlast;
    logic                 m_wready;
    logic                 m_bready;
    int                   read_bursts;
    int                   write_bursts;

    logic                 tbl_write [$];
    dcache_pkg::addr_t    tbl_addr [$];
    dcache_pkg::byte_en_t tbl_be [$];
    dcache_pkg::word_t    tbl_wdata [$];
    dcache_pkg::word_t    tbl_rdata [$];
    int                   tbl_rd_inc [$];
    int                   tbl_wr_inc [$];

    int                   tests;
    int                   errors;
    logic                 test_ok;
    logic                 timed_out;

    always #5 clk = ~clk;

    dcache_top i_dcache_top (.*);

    mem_model i_mem (.*);

    function automatic dcache_pkg::word_t mem_rule(input dcache_pkg::addr_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic add_entry(input logic wr, input dcache_pkg::addr_t addr,
                             input dcache_pkg::byte_en_t be, input dcache_pkg::word_t wdata,
                             input dcache_pkg::word_t rdata, input int rd_inc, input int wr_inc);
        tbl_write.push_back(wr);
        tbl_addr.push_back(addr);
        tbl_be.push_back(be);
        tbl_wdata.push_back(wdata);
        tbl_rdata.push_back(rdata);
        tbl_rd_inc.push_back(rd_inc);
        tbl_wr_inc.push_back(wr_inc);
    endtask

    task automatic build_table();
        // All lines below map to set 1
        add_entry(1'b0, 32'h0000_1044, 4'h0, '0, mem_rule(32'h0000_1044), 1, 0);
        add_entry(1'b0, 32'h0000_1078, 4'h0, '0, mem_rule(32'h0000_1078), 0, 0);
        add_entry(1'b1, 32'h0000_107C, 4'b0101, 32'h1122_3344, '0, 0, 0);
        add_entry(1'b0, 32'h0000_107C, 4'h0, '0, 32'hA522_1044, 0, 0);   // Bytes 0 and 2 new
        add_entry(1'b0, 32'h0000_1140, 4'h0, '0, mem_rule(32'h0000_1140), 1, 0);
        add_entry(1'b0, 32'h0000_1240, 4'h0, '0, mem_rule(32'h0000_1240), 1, 0);
        add_entry(1'b0, 32'h0000_1340, 4'h0, '0, mem_rule(32'h0000_1340), 1, 0);
        add_entry(1'b0, 32'h0000_1440, 4'h0, '0, mem_rule(32'h0000_1440), 1, 1);  // Evicts way 0
        add_entry(1'b0, 32'h0000_107C, 4'h0, '0, 32'hA522_1044, 1, 0);
        add_entry(1'b0, 32'h0000_1048, 4'h0, '0, mem_rule(32'h0000_1048), 0, 0);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch: %s got %h expected %h", name, got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("Mismatch: %s got %h expected %h", name, got, exp);
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input string desc);
        tests++;
        if (!test_ok) begin
            errors++;
        end
        $display("%s: %s", desc, test_ok ? "ok" : "FAILED");
    endtask

    task automatic apply_reset(input logic stall);
        @(posedge clk);
        rst_n    <= 1'b0;
        stall_en <= stall;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic verify_reset_outputs(input int pass_no);
        test_ok = 1'b1;
        compare_flag("m_arvalid", m_arvalid, 1'b0);
        compare_flag("m_awvalid", m_awvalid, 1'b0);
        compare_flag("m_wvalid", m_wvalid, 1'b0);
        compare_flag("m_wlast", m_wlast, 1'b0);
        compare_flag("s_rvalid", s_rvalid, 1'b0);
        compare_flag("s_wready", s_wready, 1'b0);
        compare_flag("m_rready", m_rready, 1'b1);
        compare_flag("m_bready", m_bready, 1'b1);
        report_test($sformatf("pass %0d reset outputs", pass_no));
    endtask

    task automatic run_entry(input int idx, input int pass_no);
        int   rd_start;
        int   wr_start;
        int   cycles;
        logic done;
        rd_start = read_bursts;
        wr_start = write_bursts;
        cycles   = 0;
        done     = 1'b0;
        test_ok  = 1'b1;
        @(posedge clk);
        s_addr    <= tbl_addr[idx];
        s_arvalid <= !tbl_write[idx];
        s_awvalid <= tbl_be[idx];
        s_wdata   <= tbl_wdata[idx];
        while (!done && cycles < RESP_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            done = s_rvalid || s_wready;
        end
        s_arvalid <= 1'b0;
        s_awvalid <= '0;
        assert (done) else begin
            $display("Timeout: no response from the cache within %0d cycles", RESP_TIMEOUT);
            test_ok   = 1'b0;
            timed_out = 1'b1;
        end
        if (done) begin
            compare_flag("s_rvalid", s_rvalid, !tbl_write[idx]);
            compare_flag("s_wready", s_wready, tbl_write[idx]);
            if (!tbl_write[idx]) begin
                compare_word("s_rdata", s_rdata, tbl_rdata[idx]);
            end
            compare_word("read_bursts delta", read_bursts - rd_start, tbl_rd_inc[idx]);
            compare_word("write_bursts delta", write_bursts - wr_start, tbl_wr_inc[idx]);
            if (tbl_rd_inc[idx] == 0 && tbl_wr_inc[idx] == 0) begin
                compare_word("hit latency", cycles, 3);   // Drive edge to pulse edge
            end
        end
        report_test($sformatf("pass %0d entry %0d %s %h", pass_no, idx,
                              tbl_write[idx] ? "write" : "read", tbl_addr[idx]));
    endtask

    initial begin
        rst_n     = 1'b0;
        stall_en  = 1'b0;
        s_addr    = '0;
        s_arvalid = 1'b0;
        s_awvalid = '0;
        s_wdata   = '0;
        tests     = 0;
        errors    = 0;
        test_ok   = 1'b1;
        timed_out = 1'b0;
        build_table();
        // Second pass repeats the table with memory stalls
        for (int pass_no = 0; pass_no < 2 && !timed_out; pass_no++) begin
            apply_reset(pass_no == 1);
            verify_reset_outputs(pass_no);
            for (int i = 0; i < tbl_addr.size() && !timed_out; i++) begin
                run_entry(i, pass_no);
            end
        end
        $display("%0d tests run, %0d failed", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_dcache
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
